// ==== dma_write_top.f ====
src/axi_pkg.sv
src/dma_pkg.sv
src/sync_fifo.sv
src/dma_csr_apb.sv
src/write_dest_fsm.sv
src/dma_write_top.sv
sim/tb_clock_gen.sv
sim/tb_dma_write.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_dma_write
FILELIST  = dma_write_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation passes only if the pass message shows up in its output
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_dma_write.sv ====
/* Table-driven testbench for the DMA write engine with an APB driver,
   a payload stream source and an AXI write slave model */
`default_nettype none

module tb_dma_write;
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed {
      logic [31:0] dest_addr;
      logic [11:0] length;
      int          err_burst;
      logic        backpressure;
      logic        chain;
      int          exp_bursts;
   } t_row;

   localparam int NUM_ROWS = 9;

   logic                           clk;
   logic                           reset_n;
   logic [dma_pkg::CSR_ADDR_W-1:0] paddr;
   logic                           psel;
   logic                           penable;
   logic                           pwrite;
   logic [31:0]                    pwdata;
   logic [31:0]                    prdata;
   logic                           pready;
   logic                           pslverr;
   logic                           in_valid;
   logic                           in_ready;
   logic [31:0]                    in_data;
   logic                           awvalid;
   logic                           awready;
   axi_pkg::t_aw                   aw;
   logic                           wvalid;
   logic                           wready;
   axi_pkg::t_w                    w;
   logic                           bvalid;
   axi_pkg::t_b                    b;
   logic                           bready;

   t_row         table_rows [NUM_ROWS];
   axi_pkg::t_aw exp_aw [$];
   logic         exp_aw_err [$];
   axi_pkg::t_w  exp_w [$];
   logic [31:0]  stream_q [$];
   logic [31:0]  lcg_state = 32'h948ad955;
   logic         bp_on = 1'b0;
   logic         burst_open = 1'b0;
   logic         burst_err = 1'b0;
   logic         b_due = 1'b0;
   int           aw_seen = 0;

   tb_clock_gen clock_gen (.clk, .reset_n);

   dma_write_top UUT (
      .clk, .reset_n,
      .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
      .in_valid, .in_ready, .in_data,
      .awvalid, .awready, .aw, .wvalid, .wready, .w, .bvalid, .b, .bready
   );

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // About one cycle in four is a stall while back-pressure is on
   function automatic logic stall_now();
      logic [31:0] r;
      r = next_random();
      return bp_on && (r[31:30] == 2'b00);
   endfunction

   task automatic abort_run();
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic fail_with(input string why);
      $display("Error at %0d ns: %s", $time, why);
      abort_run();
   endtask

   task automatic compare_values(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0d ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic run_watchdog(input int cycles);
      repeat (cycles) @(posedge clk);
      fail_with("timeout waiting for transfer");
   endtask

   // Each row holds dest_addr, length, SLVERR burst (-1 none), back-pressure, chain and bursts
   task automatic load_table();
      table_rows[0] = '{32'h0000_1000, 12'd5,  -1, 1'b0, 1'b0, 1};
      table_rows[1] = '{32'h0000_2000, 12'd40, -1, 1'b0, 1'b0, 3};
      table_rows[2] = '{32'h0000_4000, 12'd40, -1, 1'b1, 1'b0, 3};
      table_rows[3] = '{32'h0000_8000, 12'd16, -1, 1'b1, 1'b1, 1};
      table_rows[4] = '{32'h0000_9000, 12'd17, -1, 1'b1, 1'b1, 2};
      table_rows[5] = '{32'h0000_a000, 12'd33, -1, 1'b1, 1'b0, 3};
      table_rows[6] = '{32'h0001_0000, 12'd40, 1,  1'b0, 1'b0, 2};
      table_rows[7] = '{32'h0002_0000, 12'd20, -1, 1'b1, 1'b0, 2};
      table_rows[8] = '{32'h0003_0000, 12'd1,  -1, 1'b0, 1'b0, 1};
   endtask

   task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] data,
                             output logic [31:0] rdata);
      @(posedge clk);
      paddr   <= addr;
      pwrite  <= wr;
      pwdata  <= data;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      rdata = prdata;
      compare_values("pready", pready, 1);
      compare_values("pslverr", pslverr, 0);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] ignored;
      apb_access(addr, 1'b1, data, ignored);
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      apb_access(addr, 1'b0, '0, data);
   endtask

   // Expected bursts step 64 bytes and stop at an error burst
   task automatic queue_descriptor(input t_row row);
      int           n;
      int           nb;
      int           last;
      int           beats;
      axi_pkg::t_aw a;
      axi_pkg::t_w  d;
      n    = int'(row.length);
      nb   = (n + 15) / 16;
      last = (row.err_burst >= 0) ? row.err_burst : nb - 1;
      for (int k = 0; k <= last; k++) begin
         beats   = (k == nb - 1) ? (n - 1) % 16 + 1 : 16;
         a.addr  = row.dest_addr + 32'(64 * k);
         a.len   = 4'(beats - 1);
         a.size  = 3'd2;
         a.burst = axi_pkg::BURST_INCR;
         exp_aw.push_back(a);
         exp_aw_err.push_back(k == row.err_burst);
         for (int j = 0; j < beats; j++) begin
            d.data = next_random();
            d.strb = 4'hf;
            d.last = (j == beats - 1);
            exp_w.push_back(d);
            stream_q.push_back(d.data);
         end
      end
   endtask

   task automatic run_descriptor(input t_row row);
      logic [31:0] rd;
      queue_descriptor(row);
      apb_write(dma_pkg::DEST_ADDR, row.dest_addr);
      apb_write(dma_pkg::LENGTH, 32'(row.length));
      apb_read(dma_pkg::DEST_ADDR, rd);
      compare_values("DEST_ADDR", rd, row.dest_addr);
      apb_read(dma_pkg::LENGTH, rd);
      compare_values("LENGTH", rd, row.length);
      apb_write(dma_pkg::CONTROL, 32'h1);
   endtask

   task automatic wait_for_done(input int target, input int length);
      logic [31:0] cnt;
      logic [31:0] status;
      logic [31:0] clk_cnt;
      cnt = '0;
      while (cnt < 32'(target)) begin
         apb_read(dma_pkg::STATUS, status);
         if (status[1]) fail_with("engine stopped on error during a good transfer");
         apb_read(dma_pkg::DONE_CNT, cnt);
      end
      compare_values("DONE_CNT", cnt, target);
      apb_read(dma_pkg::VALID_CNT, cnt);
      compare_values("VALID_CNT", cnt, length);
      apb_read(dma_pkg::CLK_CNT, clk_cnt);
      if (clk_cnt < cnt) fail_with("CLK_CNT is below VALID_CNT");
   endtask

   task automatic recover_from_error(input int target);
      logic [31:0] status;
      logic [31:0] cnt;
      status = '0;
      while (status[1] !== 1'b1) begin
         apb_read(dma_pkg::STATUS, status);
      end
      compare_values("STATUS.wr_rsp_err", status[2], 1);
      compare_values("STATUS.busy", status[0], 1);
      // Any AW in this window is flagged by the slave model
      repeat (32) @(posedge clk);
      apb_read(dma_pkg::DONE_CNT, cnt);
      compare_values("DONE_CNT after error", cnt, target);
      apb_write(dma_pkg::CONTROL, 32'h2);
      apb_read(dma_pkg::STATUS, status);
      compare_values("STATUS after dispatcher reset", status, 0);
   endtask

   initial begin : axi_slave
      logic         b_fire;
      axi_pkg::t_aw a;
      axi_pkg::t_w  d;
      forever begin
         @(negedge clk);
         compare_values("bready", bready, 1);
         b_fire = bvalid && bready;
         if (b_fire) burst_open = 1'b0;
         if (awvalid && awready) begin
            if (burst_open) begin
               fail_with("AW issued before the previous burst's B response");
            end else if (exp_aw.size() == 0) begin
               fail_with("unexpected AW");
            end else begin
               a         = exp_aw.pop_front();
               burst_err = exp_aw_err.pop_front();
               compare_values("aw.addr", aw.addr, a.addr);
               compare_values("aw.len", aw.len, a.len);
               compare_values("aw.size", aw.size, a.size);
               compare_values("aw.burst", aw.burst, a.burst);
               burst_open = 1'b1;
               aw_seen++;
            end
         end
         if (wvalid && wready) begin
            if (!burst_open || exp_w.size() == 0) begin
               fail_with("W beat outside an expected burst");
            end else begin
               d = exp_w.pop_front();
               compare_values("w.data", w.data, d.data);
               compare_values("w.strb", w.strb, d.strb);
               compare_values("w.last", w.last, d.last);
               if (d.last) b_due = 1'b1;
            end
         end
         @(posedge clk);
         awready <= !stall_now();
         wready  <= !stall_now();
         if (b_fire) begin
            bvalid <= 1'b0;
         end else if (b_due && !stall_now()) begin
            bvalid <= 1'b1;
            b.resp <= burst_err ? axi_pkg::SLVERR : axi_pkg::OKAY;
            b_due = 1'b0;
         end
      end
   end

   initial begin : stream_source
      logic in_fire;
      in_fire = 1'b0;
      forever begin
         @(posedge clk);
         if (in_fire) void'(stream_q.pop_front());
         if (stream_q.size() > 0 && !stall_now()) begin
            in_valid <= 1'b1;
            in_data  <= stream_q[0];
         end else begin
            in_valid <= 1'b0;
         end
         @(negedge clk);
         in_fire = in_valid && in_ready;
      end
   end

   initial begin : main
      logic [31:0] rd;
      int          limit;
      int          done_target;
      int          batch_start;
      int          batch_bursts;
      int          i;
      paddr    = '0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      pwdata   = '0;
      in_valid = 1'b0;
      in_data  = '0;
      awready  = 1'b0;
      wready   = 1'b0;
      bvalid   = 1'b0;
      b        = '0;
      load_table();
      limit = 2000;
      for (i = 0; i < NUM_ROWS; i++) begin
         limit += 40 * int'(table_rows[i].length);
      end
      fork
         run_watchdog(limit);
      join_none
      wait (reset_n === 1'b1);
      compare_values("awvalid after reset", awvalid, 0);
      compare_values("wvalid after reset", wvalid, 0);
      apb_read(dma_pkg::STATUS, rd);
      compare_values("STATUS after reset", rd, 0);
      apb_read(dma_pkg::CLK_CNT, rd);
      compare_values("CLK_CNT after reset", rd, 0);
      apb_read(dma_pkg::VALID_CNT, rd);
      compare_values("VALID_CNT after reset", rd, 0);
      apb_read(dma_pkg::DONE_CNT, rd);
      compare_values("DONE_CNT after reset", rd, 0);
      done_target = 0;
      i = 0;
      while (i < NUM_ROWS) begin
         bp_on        = table_rows[i].backpressure;
         batch_start  = aw_seen;
         batch_bursts = 0;
         do begin
            run_descriptor(table_rows[i]);
            batch_bursts += table_rows[i].exp_bursts;
            if (table_rows[i].err_burst < 0) done_target++;
            i++;
         end while (table_rows[i-1].chain && i < NUM_ROWS);
         if (table_rows[i-1].err_burst >= 0) begin
            recover_from_error(done_target);
         end else begin
            wait_for_done(done_target, int'(table_rows[i-1].length));
         end
         compare_values("AW bursts in batch", aw_seen - batch_start, batch_bursts);
         compare_values("W beats left in batch", exp_w.size(), 0);
      end
      if (exp_aw.size() == 0 && exp_w.size() == 0 && stream_q.size() == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         fail_with("transfers left unfinished at the end of the table");
      end
   end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
/* Testbench clock and synchronous reset generator */
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 3
)(
   output logic clk,
   output logic reset_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset_n <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== src/dma_write_top.sv ====
/* DMA write engine top: APB CSR block, descriptor and data FIFOs
   and the AXI write-destination FSM */
`default_nettype none

module dma_write_top (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic [dma_pkg::CSR_ADDR_W-1:0] paddr,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [dma_pkg::CSR_DATA_W-1:0] pwdata,
   output logic [dma_pkg::CSR_DATA_W-1:0] prdata,
   output logic                           pready,
   output logic                           pslverr,
   input  logic                           in_valid,
   output logic                           in_ready,
   input  logic [axi_pkg::DATA_W-1:0]     in_data,
   output logic                           awvalid,
   input  logic                           awready,
   output axi_pkg::t_aw                   aw,
   output logic                           wvalid,
   input  logic                           wready,
   output axi_pkg::t_w                    w,
   input  logic                           bvalid,
   input  axi_pkg::t_b                    b,
   output logic                           bready
);

   logic                       desc_push;
   logic                       desc_full;
   logic                       desc_not_empty;
   logic                       desc_pop;
   logic                       wr_fsm_done;
   logic                       desc_drop;
   logic                       data_full;
   logic                       data_not_empty;
   logic                       data_rd_en;
   logic [axi_pkg::DATA_W-1:0] data_rd_data;
   dma_pkg::t_dma_descriptor   csr_descriptor;
   dma_pkg::t_dma_descriptor   head_descriptor;
   dma_pkg::t_dma_csr_control  csr_control;
   dma_pkg::t_dma_csr_status   wr_dest_status;

   assign desc_pop = wr_fsm_done | desc_drop;
   assign in_ready = ~data_full;

   dma_csr_apb csr (
      .clk, .reset_n,
      .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr,
      .desc_push, .descriptor(csr_descriptor), .desc_full,
      .csr_control, .wr_fsm_done, .wr_dest_status
   );

   sync_fifo #(
      .t_payload(dma_pkg::t_dma_descriptor),
      .DEPTH    (dma_pkg::DESC_DEPTH)
   ) desc_fifo (
      .clk, .reset_n,
      .push(desc_push), .push_data(csr_descriptor),
      .pop(desc_pop), .pop_data(head_descriptor),
      .not_empty(desc_not_empty), .full(desc_full)
   );

   // The FIFO ignores a push while full, which is exactly when in_ready is low
   sync_fifo #(
      .t_payload(logic [axi_pkg::DATA_W-1:0]),
      .DEPTH    (dma_pkg::DATA_DEPTH)
   ) data_fifo (
      .clk, .reset_n,
      .push(in_valid), .push_data(in_data),
      .pop(data_rd_en), .pop_data(data_rd_data),
      .not_empty(data_not_empty), .full(data_full)
   );

   write_dest_fsm wr_fsm (
      .clk, .reset_n,
      .desc_not_empty, .descriptor(head_descriptor),
      .wr_fsm_done, .desc_drop, .csr_control, .wr_dest_status,
      .data_not_empty, .data_rd_data, .data_rd_en,
      .awvalid, .awready, .aw,
      .wvalid, .wready, .w,
      .bvalid, .b, .bready
   );

endmodule

`default_nettype wire

// ==== src/write_dest_fsm.sv ====
/* Write-destination FSM: splits a descriptor into INCR bursts of up to
   16 beats on AXI AW/W/B and keeps status and bandwidth counters */
`default_nettype none

module write_dest_fsm (
   input  logic                        clk,
   input  logic                        reset_n,
   input  logic                        desc_not_empty,
   input  dma_pkg::t_dma_descriptor    descriptor,
   output logic                        wr_fsm_done,
   output logic                        desc_drop,
   input  dma_pkg::t_dma_csr_control   csr_control,
   output dma_pkg::t_dma_csr_status    wr_dest_status,
   input  logic                        data_not_empty,
   input  logic [axi_pkg::DATA_W-1:0]  data_rd_data,
   output logic                        data_rd_en,
   output logic                        awvalid,
   input  logic                        awready,
   output axi_pkg::t_aw                aw,
   output logic                        wvalid,
   input  logic                        wready,
   output axi_pkg::t_w                 w,
   input  logic                        bvalid,
   input  axi_pkg::t_b                 b,
   output logic                        bready
);

   localparam int LEN_W    = axi_pkg::LEN_W;
   localparam int LENGTH_W = dma_pkg::LENGTH_W;
   localparam logic [axi_pkg::SIZE_W-1:0] AW_SIZE = axi_pkg::SIZE_W'($clog2(axi_pkg::STRB_W));
   localparam logic [LENGTH_W-1:0] MAX_BEATS = LENGTH_W'(2 ** LEN_W);

   // IDLE is the all-zero code and the others are one-hot
   typedef enum logic [dma_pkg::WR_STATE_W-1:0] {
      IDLE            = 5'b00000,
      ADDR_SETUP      = 5'b00001,
      DATA_WAIT       = 5'b00010,
      WRITE_DATA      = 5'b00100,
      WAIT_FOR_WR_RSP = 5'b01000,
      ERROR           = 5'b10000
   } t_state;

   t_state                          state;
   t_state                          next;
   logic                            aw_fire;
   logic                            w_fire;
   logic                            b_fire;
   logic                            rsp_err;
   logic [axi_pkg::ADDR_W-1:0]      aw_addr;
   logic [LEN_W-1:0]                aw_len;
   logic [LEN_W-1:0]                beat_cnt;
   logic [LENGTH_W-1:0]             beats_left;
   logic [dma_pkg::PERF_CNTR_W-1:0] clk_cnt;
   logic [dma_pkg::PERF_CNTR_W-1:0] valid_cnt;

   // AXI len for the next burst given the beats still to send
   function automatic logic [LEN_W-1:0] burst_len(input logic [LENGTH_W-1:0] beats);
      return (beats > MAX_BEATS) ? '1 : LEN_W'(beats - 1'b1);
   endfunction

   assign aw_fire = awvalid & awready;
   assign w_fire  = wvalid & wready;
   assign b_fire  = bvalid & bready;
   assign rsp_err = (b.resp == axi_pkg::SLVERR);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= IDLE;
      end else begin
         state <= next;
      end
   end

   always_comb begin
      next = state;
      case (state)
         IDLE:       if (desc_not_empty) next = ADDR_SETUP;
         ADDR_SETUP: if (aw_fire) next = DATA_WAIT;
         DATA_WAIT:  if (data_not_empty) next = WRITE_DATA;
         WRITE_DATA: if (w_fire && w.last) next = WAIT_FOR_WR_RSP;
         WAIT_FOR_WR_RSP: begin
            if (b_fire) begin
               if (rsp_err) next = ERROR;
               else if (beats_left == '0) next = IDLE;
               else next = ADDR_SETUP;
            end
         end
         ERROR:      if (csr_control.reset_dispatcher) next = IDLE;
         default:    next = IDLE;
      endcase
   end

   // Burst address, length and beat bookkeeping
   always_ff @(posedge clk) begin
      if (state == IDLE) begin
         aw_addr    <= descriptor.dest_addr;
         aw_len     <= burst_len(descriptor.length);
         beats_left <= descriptor.length;
      end
      if (aw_fire) begin
         beat_cnt <= '0;
      end else if (w_fire) begin
         beat_cnt <= beat_cnt + 1'b1;
      end
      if (w_fire && w.last) begin
         beats_left <= beats_left - (LENGTH_W'(aw_len) + 1'b1);
      end
      if (state == WAIT_FOR_WR_RSP && next == ADDR_SETUP) begin
         aw_addr <= aw_addr + axi_pkg::ADDR_W'(dma_pkg::BURST_BYTES);
         aw_len  <= burst_len(beats_left);
      end
   end

   assign awvalid  = (state == ADDR_SETUP);
   assign aw.addr  = aw_addr;
   assign aw.len   = aw_len;
   assign aw.size  = AW_SIZE;
   assign aw.burst = axi_pkg::BURST_INCR;

   // wvalid follows the FIFO head, which only this block pops
   assign wvalid     = (state == WRITE_DATA) & data_not_empty;
   assign w.data     = data_rd_data;
   assign w.strb     = '1;
   assign w.last     = (beat_cnt == aw_len);
   assign data_rd_en = w_fire;

   assign bready      = 1'b1;
   assign wr_fsm_done = (state == WAIT_FOR_WR_RSP) & b_fire & ~rsp_err & (beats_left == '0);
   assign desc_drop   = (state == ERROR) & csr_control.reset_dispatcher;

   // Counters clear at descriptor start so they stay readable afterwards
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         clk_cnt   <= '0;
         valid_cnt <= '0;
      end else if (state == IDLE && next == ADDR_SETUP) begin
         clk_cnt   <= '0;
         valid_cnt <= '0;
      end else if (state != IDLE && state != ERROR) begin
         clk_cnt   <= clk_cnt + 1'b1;
         valid_cnt <= valid_cnt + dma_pkg::PERF_CNTR_W'(w_fire);
      end
   end

   assign wr_dest_status.busy                   = (state != IDLE);
   assign wr_dest_status.stopped_on_error       = (state == ERROR);
   assign wr_dest_status.wr_rsp_err             = (state == ERROR);
   assign wr_dest_status.wr_state               = state;
   assign wr_dest_status.perf.wr_dest_clk_cnt   = clk_cnt;
   assign wr_dest_status.perf.wr_dest_valid_cnt = valid_cnt;

endmodule

`default_nettype wire

// ==== src/dma_csr_apb.sv ====
/* APB register block: descriptor registers, go and dispatcher-reset
   control, completion counter and status readback */
`default_nettype none

module dma_csr_apb (
   input  logic                             clk,
   input  logic                             reset_n,
   input  logic [dma_pkg::CSR_ADDR_W-1:0]   paddr,
   input  logic                             psel,
   input  logic                             penable,
   input  logic                             pwrite,
   input  logic [dma_pkg::CSR_DATA_W-1:0]   pwdata,
   output logic [dma_pkg::CSR_DATA_W-1:0]   prdata,
   output logic                             pready,
   output logic                             pslverr,
   output logic                             desc_push,
   output dma_pkg::t_dma_descriptor         descriptor,
   input  logic                             desc_full,
   output dma_pkg::t_dma_csr_control        csr_control,
   input  logic                             wr_fsm_done,
   input  dma_pkg::t_dma_csr_status         wr_dest_status
);

   localparam int DW = dma_pkg::CSR_DATA_W;

   logic                            access;
   logic                            wr_access;
   logic                            ctrl_write;
   logic                            go_write;
   logic                            addr_mapped;
   logic [dma_pkg::PERF_CNTR_W-1:0] done_cnt;

   assign access     = psel & penable;
   assign wr_access  = access & pwrite;
   assign ctrl_write = wr_access & (paddr == dma_pkg::CONTROL);
   assign go_write   = ctrl_write & pwdata[dma_pkg::CTRL_GO_BIT];

   // Zero wait states
   assign pready = 1'b1;

   // A go with the descriptor FIFO full is dropped and flagged
   assign pslverr = (go_write & desc_full) | (access & ~addr_mapped);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         descriptor  <= '0;
         desc_push   <= 1'b0;
         csr_control <= '0;
         done_cnt    <= '0;
      end else begin
         desc_push <= go_write & ~desc_full;
         csr_control.reset_dispatcher <=
            ctrl_write & pwdata[dma_pkg::CTRL_RESET_DISPATCHER_BIT];
         if (wr_access && paddr == dma_pkg::DEST_ADDR) begin
            descriptor.dest_addr <= pwdata[axi_pkg::ADDR_W-1:0];
         end
         if (wr_access && paddr == dma_pkg::LENGTH) begin
            descriptor.length <= pwdata[dma_pkg::LENGTH_W-1:0];
         end
         if (wr_fsm_done) begin
            done_cnt <= done_cnt + 1'b1;
         end
      end
   end

   // STATUS packs busy in bit 0 and the state code from bit 3
   always_comb begin
      prdata      = '0;
      addr_mapped = 1'b1;
      case (paddr)
         dma_pkg::DEST_ADDR: prdata = DW'(descriptor.dest_addr);
         dma_pkg::LENGTH:    prdata = DW'(descriptor.length);
         dma_pkg::CONTROL:   prdata = '0;
         dma_pkg::STATUS: begin
            prdata = DW'({wr_dest_status.wr_state,
                          wr_dest_status.wr_rsp_err,
                          wr_dest_status.stopped_on_error,
                          wr_dest_status.busy});
         end
         dma_pkg::CLK_CNT:   prdata = DW'(wr_dest_status.perf.wr_dest_clk_cnt);
         dma_pkg::VALID_CNT: prdata = DW'(wr_dest_status.perf.wr_dest_valid_cnt);
         dma_pkg::DONE_CNT:  prdata = DW'(done_cnt);
         default:            addr_mapped = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/sync_fifo.sv ====
/* Synchronous circular-buffer FIFO with a type-parameter payload
   and a first-word-fall-through head */
`default_nettype none

module sync_fifo #(
   parameter type t_payload = logic [31:0],
   parameter int  DEPTH     = 4
)(
   input  logic     clk,
   input  logic     reset_n,
   input  logic     push,
   input  t_payload push_data,
   input  logic     pop,
   output t_payload pop_data,
   output logic     not_empty,
   output logic     full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   t_payload         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign full      = (count == CNT_W'(DEPTH));
   assign not_empty = (count != '0);
   assign do_push   = push & ~full;
   assign do_pop    = pop & not_empty;
   assign pop_data  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

endmodule

`default_nettype wire

// ==== src/dma_pkg.sv ====
/* DMA sizes, CSR address map and control bits,
   descriptor, control, status and perf-counter types */
`default_nettype none

package dma_pkg;

   localparam int LENGTH_W    = 12;
   localparam int PERF_CNTR_W = 32;
   localparam int DESC_DEPTH  = 4;
   localparam int DATA_DEPTH  = 32;
   localparam int WR_STATE_W  = 5;

   // One full burst of 16 beats
   localparam int BURST_BYTES = axi_pkg::STRB_W * (2 ** axi_pkg::LEN_W);

   localparam int CSR_ADDR_W = 8;
   localparam int CSR_DATA_W = 32;

   localparam logic [CSR_ADDR_W-1:0] DEST_ADDR = 8'h00;
   localparam logic [CSR_ADDR_W-1:0] LENGTH    = 8'h04;
   localparam logic [CSR_ADDR_W-1:0] CONTROL   = 8'h08;
   localparam logic [CSR_ADDR_W-1:0] STATUS    = 8'h0C;
   localparam logic [CSR_ADDR_W-1:0] CLK_CNT   = 8'h10;
   localparam logic [CSR_ADDR_W-1:0] VALID_CNT = 8'h14;
   localparam logic [CSR_ADDR_W-1:0] DONE_CNT  = 8'h18;

   localparam int CTRL_GO_BIT               = 0;
   localparam int CTRL_RESET_DISPATCHER_BIT = 1;

   typedef struct packed {
      logic [axi_pkg::ADDR_W-1:0] dest_addr;
      logic [LENGTH_W-1:0]        length;
   } t_dma_descriptor;

   typedef struct packed {
      logic reset_dispatcher;
   } t_dma_csr_control;

   typedef struct packed {
      logic [PERF_CNTR_W-1:0] wr_dest_clk_cnt;
      logic [PERF_CNTR_W-1:0] wr_dest_valid_cnt;
   } t_dma_perf_cntr;

   typedef struct packed {
      logic                  busy;
      logic                  stopped_on_error;
      logic                  wr_rsp_err;
      logic [WR_STATE_W-1:0] wr_state;
      t_dma_perf_cntr        perf;
   } t_dma_csr_status;

endpackage

`default_nettype wire

// ==== src/axi_pkg.sv ====
/* AXI write-channel widths, burst and response codes,
   and the packed structs for the AW, W and B channels */
`default_nettype none

package axi_pkg;

   localparam int ADDR_W  = 32;
   localparam int DATA_W  = 32;
   localparam int STRB_W  = DATA_W / 8;
   localparam int LEN_W   = 4;
   localparam int SIZE_W  = 3;
   localparam int BURST_W = 2;
   localparam int RESP_W  = 2;

   localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;

   localparam logic [RESP_W-1:0] OKAY   = 2'b00;
   localparam logic [RESP_W-1:0] SLVERR = 2'b10;

   typedef struct packed {
      logic [ADDR_W-1:0]  addr;
      logic [LEN_W-1:0]   len;
      logic [SIZE_W-1:0]  size;
      logic [BURST_W-1:0] burst;
   } t_aw;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
   } t_w;

   typedef struct packed {
      logic [RESP_W-1:0] resp;
   } t_b;

endpackage

`default_nettype wire
